/* Bender.yml */
package:
  name: cpuCore

sources:
  - hw/cpuIsaPkg.sv
  - hw/cpuPipePkg.sv
  - hw/fetchUnit.sv
  - hw/decodeStage.sv
  - hw/regBank.sv
  - hw/executeStage.sv
  - hw/writebackStage.sv
  - hw/cpuCore.sv
  - target: test
    files:
      - testbench/cpuCore_assertions.sv
      - testbench/cpuCore_tb.sv

/* cpuCore.f */
hw/cpuIsaPkg.sv
hw/cpuPipePkg.sv
hw/fetchUnit.sv
hw/decodeStage.sv
hw/regBank.sv
hw/executeStage.sv
hw/writebackStage.sv
hw/cpuCore.sv
testbench/cpuCore_assertions.sv
testbench/cpuCore_tb.sv

/* hw/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
	input  logic                  CLK_I,
	input  logic                  nRST_I,
	input  cpuIsaPkg::data_t      instrData,
	output cpuIsaPkg::addr_t      instrAddr,
	output cpuPipePkg::regWrite_t regWrite
);

	cpuPipePkg::fetchOut_t fetchOut;
	cpuIsaPkg::regIdx_t    srcIdx;
	cpuIsaPkg::data_t      srcVal;
	cpuIsaPkg::data_t      accVal;
	cpuPipePkg::execIn_t   execIn;
	cpuPipePkg::regWrite_t exTap;
	cpuPipePkg::regWrite_t memTap;

	// ************************************************************
	// Input side
	// ************************************************************
	fetchUnit iFetch (
		.CLK_I     (CLK_I),
		.nRST_I    (nRST_I),
		.instrData (instrData),
		.instrAddr (instrAddr),
		.fetchOut  (fetchOut)
	);

	decodeStage iDecode (
		.CLK_I    (CLK_I),
		.nRST_I   (nRST_I),
		.fetchOut (fetchOut),
		.srcIdx   (srcIdx),
		.srcVal   (srcVal),
		.accVal   (accVal),
		.execIn   (execIn)
	);

	executeStage iExecute (
		.CLK_I  (CLK_I),
		.nRST_I (nRST_I),
		.execIn (execIn),
		.exTap  (exTap),
		.memTap (memTap)
	);

	// Retire port doubles as the bank write
	writebackStage iWriteback (
		.CLK_I  (CLK_I),
		.nRST_I (nRST_I),
		.memTap (memTap),
		.wbTap  (regWrite)
	);

	regBank iRegBank (
		.CLK_I  (CLK_I),
		.nRST_I (nRST_I),
		.srcIdx (srcIdx),
		.srcVal (srcVal),
		.accVal (accVal),
		.exTap  (exTap),
		.memTap (memTap),
		.wbTap  (regWrite)
	);

endmodule

/* hw/cpuIsaPkg.sv */
package cpuIsaPkg;

	// ************************************************************
	// Widths
	// ************************************************************
	localparam int DataWidth   = 8;
	localparam int AddrWidth   = 14;
	localparam int RegIdxWidth = 3;

	typedef logic [DataWidth-1:0]   data_t;
	typedef logic [AddrWidth-1:0]   addr_t;
	typedef logic [RegIdxWidth-1:0] regIdx_t;

	// Register codes
	localparam regIdx_t RegA   = 3'd0;
	localparam regIdx_t RegH   = 3'd5;
	localparam regIdx_t RegL   = 3'd6;
	localparam regIdx_t RegMem = 3'd7;  // Memory operand, not implemented

	// ************************************************************
	// Opcode fields
	// ************************************************************
	localparam logic [1:0] ClassImm    = 2'b00;
	localparam logic [1:0] ClassAluReg = 2'b10;
	localparam logic [1:0] ClassMove   = 2'b11;

	// Low three bits when class is 00
	localparam logic [2:0] SubInc     = 3'b000;
	localparam logic [2:0] SubDcr     = 3'b001;
	localparam logic [2:0] SubRot     = 3'b010;
	localparam logic [2:0] SubAluImm  = 3'b100;
	localparam logic [2:0] SubLoadImm = 3'b110;

	localparam logic [2:0] FunAdd = 3'd0;
	localparam logic [2:0] FunAdc = 3'd1;
	localparam logic [2:0] FunSub = 3'd2;
	localparam logic [2:0] FunSbb = 3'd3;
	localparam logic [2:0] FunAnd = 3'd4;
	localparam logic [2:0] FunXor = 3'd5;
	localparam logic [2:0] FunOr  = 3'd6;
	localparam logic [2:0] FunCmp = 3'd7;

	localparam logic [1:0] RotRlc = 2'd0;
	localparam logic [1:0] RotRrc = 2'd1;
	localparam logic [1:0] RotRal = 2'd2;
	localparam logic [1:0] RotRar = 2'd3;

	// Same byte seen as register form or as function form
	typedef union packed {
		struct packed {
			logic [1:0] cls;
			regIdx_t    dst;
			regIdx_t    src;
		} regForm;
		struct packed {
			logic [1:0] cls;
			logic [2:0] fun;
			logic [2:0] sub;
		} funForm;
	} opcode_u;

endpackage

/* hw/cpuPipePkg.sv */
package cpuPipePkg;

	typedef enum logic [2:0] {
		OpNone,
		OpAlu,
		OpRot,
		OpInc,
		OpDcr,
		OpMove   // Also used by load immediate
	} opKind_e;

	// Fetch to decode
	typedef struct packed {
		logic               valid;
		cpuIsaPkg::opcode_u opcode;
		cpuIsaPkg::data_t   imm;
	} fetchOut_t;

	// Decode to execute
	typedef struct packed {
		logic               valid;
		opKind_e            kind;
		logic [2:0]         fun;       // ALU function or rotate code
		cpuIsaPkg::regIdx_t dst;
		logic               writesReg;
		cpuIsaPkg::data_t   opA;
		cpuIsaPkg::data_t   opB;
	} execIn_t;

	// Forwarding taps, bank write and retire port
	typedef struct packed {
		logic               valid;
		cpuIsaPkg::regIdx_t idx;
		cpuIsaPkg::data_t   data;
	} regWrite_t;

endpackage

/* hw/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input  logic                  CLK_I,
	input  logic                  nRST_I,
	input  cpuPipePkg::fetchOut_t fetchOut,
	output cpuIsaPkg::regIdx_t    srcIdx,
	input  cpuIsaPkg::data_t      srcVal,
	input  cpuIsaPkg::data_t      accVal,
	output cpuPipePkg::execIn_t   execIn
);

	cpuIsaPkg::opcode_u  op;
	cpuPipePkg::execIn_t execNext;

	assign op = fetchOut.opcode;

	// INC and DCR read their own destination
	assign srcIdx = (op.funForm.cls == cpuIsaPkg::ClassImm) ? op.regForm.dst : op.regForm.src;

	// ************************************************************
	// Classification
	// ************************************************************
	always_comb begin
		execNext           = '0;
		execNext.kind      = cpuPipePkg::OpNone;
		execNext.fun       = op.funForm.fun;
		execNext.dst       = op.regForm.dst;
		execNext.opA       = accVal;
		execNext.opB       = srcVal;
		case (op.funForm.cls)
			cpuIsaPkg::ClassImm: begin
				case (op.funForm.sub)
					cpuIsaPkg::SubInc, cpuIsaPkg::SubDcr: begin
						// Destination A here is the NOP encoding
						if (op.regForm.dst != cpuIsaPkg::RegA &&
								op.regForm.dst != cpuIsaPkg::RegMem) begin
							execNext.writesReg = 1'b1;
							execNext.opA       = srcVal;
							if (op.funForm.sub == cpuIsaPkg::SubInc) begin
								execNext.kind = cpuPipePkg::OpInc;
								execNext.opB  = 8'h01;
							end else begin
								execNext.kind = cpuPipePkg::OpDcr;
								execNext.opB  = 8'hFF;
							end
						end
					end
					cpuIsaPkg::SubRot: begin
						if (!op.funForm.fun[2]) begin
							execNext.kind      = cpuPipePkg::OpRot;
							execNext.dst       = cpuIsaPkg::RegA;
							execNext.writesReg = 1'b1;
						end
					end
					cpuIsaPkg::SubAluImm: begin
						execNext.kind      = cpuPipePkg::OpAlu;
						execNext.dst       = cpuIsaPkg::RegA;
						execNext.opB       = fetchOut.imm;
						execNext.writesReg = (op.funForm.fun != cpuIsaPkg::FunCmp);
					end
					cpuIsaPkg::SubLoadImm: begin
						if (op.regForm.dst != cpuIsaPkg::RegMem) begin
							execNext.kind      = cpuPipePkg::OpMove;
							execNext.opB       = fetchOut.imm;
							execNext.writesReg = 1'b1;
						end
					end
					default: ;
				endcase
			end
			cpuIsaPkg::ClassAluReg: begin
				if (op.regForm.src != cpuIsaPkg::RegMem) begin
					execNext.kind      = cpuPipePkg::OpAlu;
					execNext.dst       = cpuIsaPkg::RegA;
					execNext.writesReg = (op.funForm.fun != cpuIsaPkg::FunCmp);
				end
			end
			cpuIsaPkg::ClassMove: begin
				if (op.regForm.dst != cpuIsaPkg::RegMem && op.regForm.src != cpuIsaPkg::RegMem) begin
					execNext.kind      = cpuPipePkg::OpMove;
					execNext.writesReg = 1'b1;
				end
			end
			default: ;   // Jumps and calls fall through as NOP
		endcase
		execNext.valid = fetchOut.valid && (execNext.kind != cpuPipePkg::OpNone);
	end

	always_ff @(posedge CLK_I) begin
		if (!nRST_I)
			execIn.valid <= 1'b0;
		else
			execIn <= execNext;
	end

endmodule

/* hw/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input  logic                  CLK_I,
	input  logic                  nRST_I,
	input  cpuPipePkg::execIn_t   execIn,
	output cpuPipePkg::regWrite_t exTap,
	output cpuPipePkg::regWrite_t memTap
);

	logic                     carry;
	logic                     carryNext;
	logic [cpuIsaPkg::DataWidth:0] wide;   // Result with carry or borrow on top
	cpuIsaPkg::data_t         result;

	// ************************************************************
	// ALU
	// ************************************************************
	always_comb begin
		wide      = '0;
		result    = execIn.opB;   // Move and load immediate
		carryNext = carry;
		case (execIn.kind)
			cpuPipePkg::OpAlu: begin
				case (execIn.fun)
					cpuIsaPkg::FunAdd: wide = {1'b0, execIn.opA} + {1'b0, execIn.opB};
					cpuIsaPkg::FunAdc: wide = {1'b0, execIn.opA} + {1'b0, execIn.opB} + carry;
					cpuIsaPkg::FunSub: wide = {1'b0, execIn.opA} - {1'b0, execIn.opB};
					cpuIsaPkg::FunSbb: wide = {1'b0, execIn.opA} - {1'b0, execIn.opB} - carry;
					cpuIsaPkg::FunAnd: wide = {1'b0, execIn.opA & execIn.opB};
					cpuIsaPkg::FunXor: wide = {1'b0, execIn.opA ^ execIn.opB};
					cpuIsaPkg::FunOr:  wide = {1'b0, execIn.opA | execIn.opB};
					default:           wide = {1'b0, execIn.opA} - {1'b0, execIn.opB};  // CMP
				endcase
				result    = wide[cpuIsaPkg::DataWidth-1:0];
				carryNext = wide[cpuIsaPkg::DataWidth];
			end
			cpuPipePkg::OpRot: begin
				case (execIn.fun[1:0])
					cpuIsaPkg::RotRlc: begin
						result    = {execIn.opA[6:0], execIn.opA[7]};
						carryNext = execIn.opA[7];
					end
					cpuIsaPkg::RotRrc: begin
						result    = {execIn.opA[0], execIn.opA[7:1]};
						carryNext = execIn.opA[0];
					end
					cpuIsaPkg::RotRal: begin
						result    = {execIn.opA[6:0], carry};   // Through carry
						carryNext = execIn.opA[7];
					end
					default: begin
						result    = {carry, execIn.opA[7:1]};
						carryNext = execIn.opA[0];
					end
				endcase
			end
			// Adding all-ones decrements, carry untouched
			cpuPipePkg::OpInc, cpuPipePkg::OpDcr: result = execIn.opA + execIn.opB;
			default: ;
		endcase
	end

	always_comb begin
		exTap.valid = execIn.valid & execIn.writesReg;
		exTap.idx   = execIn.dst;
		exTap.data  = result;
	end

	// Flag and result register
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			carry        <= 1'b0;
			memTap.valid <= 1'b0;
		end else begin
			if (execIn.valid)
				carry <= carryNext;
			memTap <= exTap;
		end
	end

endmodule

/* hw/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
	input  logic                  CLK_I,
	input  logic                  nRST_I,
	input  cpuIsaPkg::data_t      instrData,
	output cpuIsaPkg::addr_t      instrAddr,
	output cpuPipePkg::fetchOut_t fetchOut
);

	cpuIsaPkg::addr_t   pc;
	cpuIsaPkg::opcode_u opByte;   // Older byte of the window
	cpuIsaPkg::data_t   immByte;  // Newer byte
	logic               opHeld;
	logic               immHeld;
	logic               skip;     // Window holds an immediate already consumed
	logic               twoByte;

	assign instrAddr = pc;

	// ALU immediate and load immediate carry a second byte
	always_comb begin
		twoByte = 1'b0;
		if (opByte.funForm.cls == cpuIsaPkg::ClassImm) begin
			if (opByte.funForm.sub == cpuIsaPkg::SubAluImm)
				twoByte = 1'b1;
			else if (opByte.funForm.sub == cpuIsaPkg::SubLoadImm &&
					opByte.regForm.dst != cpuIsaPkg::RegMem)
				twoByte = 1'b1;
		end
	end

	always_comb begin
		fetchOut.valid  = opHeld & immHeld & ~skip;
		fetchOut.opcode = opByte;
		fetchOut.imm    = immByte;
	end

	// ************************************************************
	// Program counter and window control
	// ************************************************************
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			pc      <= '0;
			opHeld  <= 1'b0;
			immHeld <= 1'b0;
			skip    <= 1'b0;
		end else begin
			pc      <= pc + 1'b1;   // No branches, always counts up
			immHeld <= 1'b1;
			opHeld  <= immHeld;
			skip    <= fetchOut.valid & twoByte;
		end
	end

	// Byte window shifts every cycle
	always_ff @(posedge CLK_I) begin
		immByte <= instrData;
		opByte  <= immByte;
	end

endmodule

/* hw/regBank.sv */
`timescale 1ns/1ps

module regBank (
	input  logic                  CLK_I,
	input  logic                  nRST_I,
	input  cpuIsaPkg::regIdx_t    srcIdx,
	output cpuIsaPkg::data_t      srcVal,
	output cpuIsaPkg::data_t      accVal,
	input  cpuPipePkg::regWrite_t exTap,
	input  cpuPipePkg::regWrite_t memTap,
	input  cpuPipePkg::regWrite_t wbTap
);

	cpuIsaPkg::data_t regs [0:6];

	// Youngest producer wins
	function automatic cpuIsaPkg::data_t lookup(input cpuIsaPkg::regIdx_t idx);
		cpuIsaPkg::data_t val;
		if (idx == cpuIsaPkg::RegMem)
			val = '0;
		else if (exTap.valid && exTap.idx == idx)
			val = exTap.data;
		else if (memTap.valid && memTap.idx == idx)
			val = memTap.data;
		else if (wbTap.valid && wbTap.idx == idx)
			val = wbTap.data;   // Bank not yet updated this cycle
		else
			val = regs[idx];
		return val;
	endfunction

	always_comb begin
		srcVal = lookup(srcIdx);
		accVal = lookup(cpuIsaPkg::RegA);
	end

	// ************************************************************
	// Bank write
	// ************************************************************
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			for (int i = 0; i < 7; i++)
				regs[i] <= '0;
		end else if (wbTap.valid && wbTap.idx != cpuIsaPkg::RegMem) begin
			regs[wbTap.idx] <= wbTap.data;
		end
	end

endmodule

/* hw/writebackStage.sv */
`timescale 1ns/1ps

module writebackStage (
	input  logic                  CLK_I,
	input  logic                  nRST_I,
	input  cpuPipePkg::regWrite_t memTap,
	output cpuPipePkg::regWrite_t wbTap
);

	// ************************************************************
	// Last stage register
	// ************************************************************
	// Feeds the bank write and the retire stream alike
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			wbTap.valid <= 1'b0;
		end else begin
			wbTap.valid <= memTap.valid;
			if (memTap.valid) begin
				wbTap.idx  <= memTap.idx;
				wbTap.data <= memTap.data;
			end
		end
	end

endmodule

/* testbench/cpuCore_assertions.sv */
`timescale 1ns/1ps

module cpuCore_assertions (
	input logic                  CLK_I,
	input logic                  nRST_I,
	input cpuIsaPkg::addr_t      instrAddr,
	input cpuPipePkg::regWrite_t regWrite
);

	// ************************************************************
	// Retire port
	// ************************************************************
	resetQuiet: assert property (@(posedge CLK_I) !nRST_I |=> !regWrite.valid)
		else $error("regWrite valid right after a reset edge");

	releaseQuiet: assert property (@(posedge CLK_I) $rose(nRST_I) |=> !regWrite.valid)
		else $error("regWrite valid in the first cycle out of reset");

	noMemWrite: assert property (@(posedge CLK_I) disable iff (!nRST_I)
		regWrite.valid |-> regWrite.idx != cpuIsaPkg::RegMem)
		else $error("regWrite targets the memory register code");

	// Fetch address counts from zero
	addrStart: assert property (@(posedge CLK_I) $rose(nRST_I) |-> instrAddr == '0)
		else $error("instrAddr not zero after reset");

	addrStep: assert property (@(posedge CLK_I) nRST_I && $past(nRST_I) |->
		instrAddr == cpuIsaPkg::addr_t'($past(instrAddr) + 1'b1))
		else $error("instrAddr did not step by one");

endmodule

bind cpuCore cpuCore_assertions i_checks (
	.CLK_I     (CLK_I),
	.nRST_I    (nRST_I),
	.instrAddr (instrAddr),
	.regWrite  (regWrite)
);

/* testbench/cpuCore_tb.sv */
`timescale 1ns/1ps

module cpuCore_tb;

	localparam int ProgLen     = 512;
	localparam int GenLimit    = 480;   // Random code stops here, rest is NOP
	localparam int ResetCycles = 5;
	localparam int DirLen      = 32;

	// Directed head of the program
	localparam logic [8*DirLen-1:0] DirectedProg = {
		8'h0E, 8'h3C, 8'h08, 8'hD1, 8'h82, 8'hD8, 8'h00, 8'hE3,   // Chains at distance 1 to 4
		8'h00, 8'h00, 8'hEC, 8'h00, 8'h00, 8'h00, 8'hF5, 8'h06,
		8'hFF, 8'h04, 8'h01, 8'h08, 8'h0C, 8'h00, 8'h12, 8'h1C,   // ADI, INC, ACI, RAL, SBI
		8'h05, 8'h11, 8'h9A, 8'h1A, 8'h3C, 8'hC8, 8'h16, 8'hD9    // Immediates posing as moves
	};

	logic                  CLK_I;
	logic                  nRST_I;
	cpuIsaPkg::data_t      instrData;
	cpuIsaPkg::addr_t      instrAddr;
	cpuPipePkg::regWrite_t regWrite;

	cpuIsaPkg::data_t      prog [0:ProgLen-1];
	cpuIsaPkg::data_t      refRegs [0:6];
	logic                  refCarry;
	cpuPipePkg::regWrite_t expQ [$];
	cpuPipePkg::regWrite_t expWrite;
	int unsigned           seed;
	int                    expTotal;
	int                    seenCount;
	int                    errCount;
	int                    cycleCount;

	cpuCore i_dut (
		.CLK_I     (CLK_I),
		.nRST_I    (nRST_I),
		.instrData (instrData),
		.instrAddr (instrAddr),
		.regWrite  (regWrite)
	);

	initial begin
		CLK_I = 1'b0;
		forever #20 CLK_I = ~CLK_I;
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %0t: %s is %0h, expected %0h", $time, name, got, exp);
			errCount++;
		end
	endtask

	function automatic cpuIsaPkg::data_t storeRead(input int addr);
		return (addr < ProgLen) ? prog[addr] : 8'h00;   // NOP past the end
	endfunction

	// ************************************************************
	// Reference model
	// ************************************************************
	task automatic recordWrite(input cpuIsaPkg::regIdx_t idx, input cpuIsaPkg::data_t val);
		cpuPipePkg::regWrite_t w;
		refRegs[idx] = val;
		w.valid = 1'b1;
		w.idx   = idx;
		w.data  = val;
		expQ.push_back(w);
	endtask

	task automatic aluReference(input logic [2:0] fun, input cpuIsaPkg::data_t b);
		int a;
		int r;
		a = refRegs[cpuIsaPkg::RegA];
		case (fun)
			3'd0, 3'd1: begin
				r        = a + int'(b) + ((fun == 3'd1) ? int'(refCarry) : 0);
				refCarry = (r > 255);
			end
			3'd2, 3'd3, 3'd7: begin
				r        = a - int'(b) - ((fun == 3'd3) ? int'(refCarry) : 0);
				refCarry = (r < 0);   // Borrow
			end
			3'd4: r = a & int'(b);
			3'd5: r = a ^ int'(b);
			default: r = a | int'(b);
		endcase
		if (fun inside {3'd4, 3'd5, 3'd6})
			refCarry = 1'b0;
		if (fun != 3'd7)   // Compare only sets carry
			recordWrite(cpuIsaPkg::RegA, r[7:0]);
	endtask

	task automatic runReference;
		int               pc;
		cpuIsaPkg::data_t op;
		cpuIsaPkg::data_t a;
		refCarry = 1'b0;
		for (int i = 0; i < 7; i++)
			refRegs[i] = '0;
		pc = 0;
		while (pc < ProgLen) begin
			op = prog[pc];
			a  = refRegs[cpuIsaPkg::RegA];
			case (op[7:6])
				2'b11: recordWrite(op[5:3], refRegs[op[2:0]]);
				2'b10: aluReference(op[5:3], refRegs[op[2:0]]);
				default: begin
					case (op[2:0])
						3'b000: if (op[5:3] != 3'd0) recordWrite(op[5:3], refRegs[op[5:3]] + 8'd1);
						3'b001: if (op[5:3] != 3'd0) recordWrite(op[5:3], refRegs[op[5:3]] - 8'd1);
						3'b010: begin
							case (op[4:3])
								2'd0: a = {a[6:0], a[7]};
								2'd1: a = {a[0], a[7:1]};
								2'd2: a = {a[6:0], refCarry};
								default: a = {refCarry, a[7:1]};
							endcase
							// Old A supplies the bit shifted out
							refCarry = op[3] ? refRegs[cpuIsaPkg::RegA][0] : refRegs[cpuIsaPkg::RegA][7];
							recordWrite(cpuIsaPkg::RegA, a);
						end
						3'b100: begin
							aluReference(op[5:3], storeRead(pc + 1));
							pc++;
						end
						3'b110: begin
							recordWrite(op[5:3], storeRead(pc + 1));
							pc++;
						end
						default: ;
					endcase
				end
			endcase
			pc++;
		end
		expTotal = expQ.size();
	endtask

	task automatic buildProgram;
		int               ptr;
		int               kind;
		logic [2:0]       d;
		logic [2:0]       s;
		logic [2:0]       f;
		logic [2:0]       n;
		cpuIsaPkg::data_t rnd;
		for (int i = 0; i < ProgLen; i++)
			prog[i] = 8'h00;
		for (int i = 0; i < DirLen; i++)
			prog[i] = DirectedProg[8*(DirLen-1-i) +: 8];
		ptr = DirLen;
		while (ptr < GenLimit) begin
			kind = $urandom_range(0, 7);
			d    = $urandom_range(0, 6);
			s    = $urandom_range(0, 6);
			f    = $urandom_range(0, 7);
			n    = $urandom_range(1, 6);   // INC A and DCR A are NOPs
			rnd  = $urandom;
			case (kind)
				0: prog[ptr] = {7'b0, f[0]};
				1: prog[ptr] = {2'b00, n, 2'b00, f[0]};
				2: prog[ptr] = {3'b000, f[1:0], 3'b010};
				3: prog[ptr] = {2'b00, f, 3'b100};
				4: prog[ptr] = {2'b00, d, 3'b110};
				5: prog[ptr] = {2'b10, f, s};
				default: prog[ptr] = {2'b11, d, s};
			endcase
			if (kind == 3 || kind == 4) begin
				ptr++;
				prog[ptr] = ($urandom_range(0, 3) == 0) ? {2'b11, d, s} : rnd;
			end
			ptr++;
		end
	endtask

	// Store answers shortly after each edge
	always @(posedge CLK_I) begin
		#1;
		instrData = storeRead(instrAddr);
	end

	// ************************************************************
	// Retire monitor
	// ************************************************************
	always @(negedge CLK_I) begin
		if (nRST_I) begin
			checkValue("instrAddr", instrAddr, cycleCount);
			cycleCount++;
			if (regWrite.valid) begin
				if (expQ.size() == 0) begin
					$display("Extra register write to r%0d at %0t, the model has none left",
						regWrite.idx, $time);
					errCount++;
				end else begin
					expWrite = expQ.pop_front();
					checkValue("regWrite.idx", regWrite.idx, expWrite.idx);
					checkValue("regWrite.data", regWrite.data, expWrite.data);
				end
				seenCount++;
			end
		end
	end

	initial begin
		seed       = 32'h5994_f6f2;
		void'($urandom(seed));
		nRST_I     = 1'b0;
		instrData  = 8'h00;
		errCount   = 0;
		seenCount  = 0;
		cycleCount = 0;
		buildProgram();
		runReference();
		repeat (ResetCycles) @(posedge CLK_I);
		#1 nRST_I = 1'b1;
		wait (seenCount == expTotal);
		repeat (20) @(negedge CLK_I);   // Catch stray writes
		checkValue("writeCount", seenCount, expTotal);
		$display("Errors: %0d, writes seen: %0d, writes expected: %0d",
			errCount, seenCount, expTotal);
		if (errCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (ResetCycles + ProgLen + 50) @(posedge CLK_I);
		$display("Timeout: only %0d of %0d register writes arrived", seenCount, expTotal);
		errCount++;
		$display("Errors: %0d, writes seen: %0d, writes expected: %0d",
			errCount, seenCount, expTotal);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
